// File: design/data_mem.sv
`default_nettype none

module data_mem import lsu_pkg::*; (
  input  wire logic     clock,
  input  wire logic     reset,
  input  wire logic     mem_valid_i,
  input  wire mem_req_t mem_req_i,
  output mem_block_t    rdata_o
);

  mem_block_t           mem_q [MEM_WORDS];
  mem_block_t           rdata_q;
  logic [ADDR_W-4:0]    word_idx;
  logic [7:0]           lane_be;
  mem_block_t           lane_data;
  logic                 wr_en;
  logic                 rd_en;

  // doubleword index and byte lane from the address
  assign word_idx  = mem_req_i.addr[ADDR_W-1:3];
  assign lane_be   = byte_mask(mem_req_i.size) << mem_req_i.addr[2:0];
  assign lane_data = mem_req_i.data << {mem_req_i.addr[2:0], 3'b000};

  assign wr_en = mem_valid_i && (mem_req_i.cmd == mem_store);
  assign rd_en = mem_valid_i && (mem_req_i.cmd == mem_load);

  // ========================================
  // write port
  // ========================================

  // memory starts out all zero
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en) begin
      // enabled bytes only
      for (int b = 0; b < 8; b++) begin
        if (lane_be[b]) begin
          mem_q[word_idx][b*8 +: 8] <= lane_data[b*8 +: 8];
        end
      end
    end
  end

  // ========================================
  // read port
  // ========================================

  // whole doubleword, one cycle latency
  always_ff @(posedge clock) begin
    if (rd_en) begin
      rdata_q <= mem_q[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: design/dcache_arbiter.sv
`default_nettype none

module dcache_arbiter import lsu_pkg::*; (
  input  wire logic     clock,
  input  wire logic     reset,
  input  wire logic     ld_req_valid_i,
  input  wire mem_req_t ld_req_i,
  input  wire logic     st_req_valid_i,
  input  wire mem_req_t st_req_i,
  output logic          ld_accept_o,
  output logic          st_accept_o,
  output logic          mem_valid_o,
  output mem_req_t      mem_req_o,
  output logic          rd_pending_o
);

  logic rd_pending_q;

  // ========================================
  // fixed priority grant
  // ========================================

  // loads first, store drain takes the idle cycles
  assign ld_accept_o = ld_req_valid_i;
  assign st_accept_o = st_req_valid_i && !ld_req_valid_i;

  assign mem_valid_o = ld_req_valid_i || st_req_valid_i;
  assign mem_req_o   = ld_req_valid_i ? ld_req_i : st_req_i;

  // high in the cycle the read data comes back
  always_ff @(posedge clock) begin
    if (reset) begin
      rd_pending_q <= 1'b0;
    end else begin
      rd_pending_q <= ld_accept_o && (ld_req_i.cmd == mem_load);
    end
  end

  assign rd_pending_o = rd_pending_q;

endmodule

`default_nettype wire

// File: design/load_unit.sv
`default_nettype none

module load_unit import lsu_pkg::*; (
  input  wire logic       clock,
  input  wire logic       reset,
  input  wire logic       load_req_i,
  input  wire addr_t      load_addr_i,
  input  wire mem_size_e  load_size_i,
  input  wire fwd_resp_t  fwd_i,
  input  wire logic       ld_req_accept_i,
  input  wire mem_block_t mem_rdata_i,
  output logic            load_busy_o,
  output logic            load_done_o,
  output mem_block_t      load_data_o,
  output addr_t           probe_addr_o,
  output mem_size_e       probe_size_o,
  output logic            ld_req_valid_o,
  output mem_req_t        ld_req_o
);

  load_state_e state_q;
  addr_t       addr_q;
  mem_size_e   size_q;
  logic        done_q;
  mem_block_t  data_q;
  logic [2:0]  fwd_off;

  // shift the addressed bytes down, keep only the access width
  function automatic mem_block_t align_bytes(mem_block_t raw, logic [2:0] off, mem_size_e sz);
    mem_block_t shifted;
    mem_block_t keep;
    logic [7:0] be;
    shifted = raw >> {off, 3'b000};
    be      = byte_mask(sz);
    for (int i = 0; i < 8; i++) begin
      keep[i*8 +: 8] = {8{be[i]}};
    end
    return shifted & keep;
  endfunction

  // load byte position inside the forwarding store
  assign fwd_off = addr_q[2:0] - fwd_i.addr[2:0];

  assign load_busy_o  = (state_q != load_idle);
  assign load_done_o  = done_q;
  assign load_data_o  = data_q;
  assign probe_addr_o = addr_q;
  assign probe_size_o = size_q;

  // memory read only once the queue reports no overlap
  assign ld_req_valid_o = (state_q == load_probe) && !fwd_i.hit && !fwd_i.pending;
  assign ld_req_o.cmd   = mem_load;
  assign ld_req_o.addr  = addr_q;
  assign ld_req_o.size  = size_q;
  assign ld_req_o.data  = '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= load_idle;
      done_q  <= 1'b0;
    end else begin
      // done is a single-cycle pulse
      done_q <= 1'b0;
      case (state_q)
        load_idle: begin
          if (load_req_i) begin
            addr_q  <= load_addr_i;
            size_q  <= load_size_i;
            state_q <= load_probe;
          end
        end
        load_probe: begin
          if (fwd_i.hit) begin
            data_q  <= align_bytes(fwd_i.data, fwd_off, size_q);
            done_q  <= 1'b1;
            state_q <= load_idle;
          end else if (ld_req_valid_o && ld_req_accept_i) begin
            state_q <= load_wait_mem;
          end
          // pending answer keeps probing
        end
        load_wait_mem: begin
          // read data arrives the cycle after the accept
          data_q  <= align_bytes(mem_rdata_i, addr_q[2:0], size_q);
          done_q  <= 1'b1;
          state_q <= load_idle;
        end
        default: state_q <= load_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // ========================================
  // sizes
  // ========================================

  // store queue depth and pointer widths
  localparam int SQ_SIZE   = 8;
  localparam int SQ_IDX_W  = 3;
  localparam int SQ_CNT_W  = 4;

  // byte address and rob tag widths
  localparam int ADDR_W    = 12;
  localparam int ROB_IDX_W = 5;

  // 512 doublewords fill the 12-bit byte space
  localparam int MEM_WORDS = 512;

  // ========================================
  // scalar types and enums
  // ========================================

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;
  // store data sits in the low bytes
  typedef logic [63:0]          mem_block_t;

  typedef enum logic [1:0] {
    size_byte   = 2'd0,
    size_half   = 2'd1,
    size_word   = 2'd2,
    size_double = 2'd3
  } mem_size_e;

  typedef enum logic [0:0] {
    mem_load  = 1'b0,
    mem_store = 1'b1
  } mem_cmd_e;

  typedef enum logic [1:0] {
    load_idle     = 2'd0,
    load_probe    = 2'd1,
    load_wait_mem = 2'd2
  } load_state_e;

  // ========================================
  // structs
  // ========================================

  // one store queue slot, 86 bits
  typedef struct packed {
    logic       valid;
    addr_t      addr;
    mem_size_e  size;
    rob_idx_t   rob_idx;
    logic       data_valid;
    mem_block_t data;
    logic       committed;
  } sq_entry_t;

  // one request on the memory port, 79 bits
  typedef struct packed {
    mem_cmd_e   cmd;
    addr_t      addr;
    mem_size_e  size;
    mem_block_t data;
  } mem_req_t;

  // store-to-load forwarding answer, 78 bits
  typedef struct packed {
    logic       hit;
    logic       pending;
    mem_block_t data;
    addr_t      addr;
  } fwd_resp_t;

  // ========================================
  // size helpers
  // ========================================

  // access length in bytes
  function automatic logic [3:0] size_bytes(mem_size_e sz);
    case (sz)
      size_byte: return 4'd1;
      size_half: return 4'd2;
      size_word: return 4'd4;
      default:   return 4'd8;
    endcase
  endfunction

  // byte enables of an access at lane zero
  function automatic logic [7:0] byte_mask(mem_size_e sz);
    case (sz)
      size_byte: return 8'h01;
      size_half: return 8'h03;
      size_word: return 8'h0f;
      default:   return 8'hff;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: design/lsu_top.sv
`default_nettype none

module lsu_top import lsu_pkg::*; (
  input  wire logic       clock,
  input  wire logic       reset,
  // store queue side
  input  wire logic       enq_valid_i,
  input  wire addr_t      enq_addr_i,
  input  wire mem_size_e  enq_size_i,
  input  wire rob_idx_t   enq_rob_idx_i,
  input  wire logic       data_valid_i,
  input  wire mem_block_t data_i,
  input  wire rob_idx_t   data_rob_idx_i,
  input  wire logic       commit_valid_i,
  input  wire rob_idx_t   commit_rob_idx_i,
  // load side
  input  wire logic       load_req_i,
  input  wire addr_t      load_addr_i,
  input  wire mem_size_e  load_size_i,
  output logic            sq_full_o,
  output logic            sq_empty_o,
  output logic            load_busy_o,
  output logic            load_done_o,
  output mem_block_t      load_data_o
);

  fwd_resp_t  fwd;
  addr_t      probe_addr;
  mem_size_e  probe_size;
  logic       ld_req_valid;
  mem_req_t   ld_req;
  logic       ld_accept;
  logic       st_req_valid;
  mem_req_t   st_req;
  logic       st_accept;
  logic       mem_valid;
  mem_req_t   mem_req;
  mem_block_t mem_rdata;

  store_queue sq_i (
    .clock            (clock),
    .reset            (reset),
    .enq_valid_i      (enq_valid_i),
    .enq_addr_i       (enq_addr_i),
    .enq_size_i       (enq_size_i),
    .enq_rob_idx_i    (enq_rob_idx_i),
    .data_valid_i     (data_valid_i),
    .data_i           (data_i),
    .data_rob_idx_i   (data_rob_idx_i),
    .commit_valid_i   (commit_valid_i),
    .commit_rob_idx_i (commit_rob_idx_i),
    .load_addr_i      (probe_addr),
    .load_size_i      (probe_size),
    .st_req_accept_i  (st_accept),
    .sq_full_o        (sq_full_o),
    .sq_empty_o       (sq_empty_o),
    .fwd_o            (fwd),
    .st_req_valid_o   (st_req_valid),
    .st_req_o         (st_req)
  );

  load_unit lu_i (
    .clock           (clock),
    .reset           (reset),
    .load_req_i      (load_req_i),
    .load_addr_i     (load_addr_i),
    .load_size_i     (load_size_i),
    .fwd_i           (fwd),
    .ld_req_accept_i (ld_accept),
    .mem_rdata_i     (mem_rdata),
    .load_busy_o     (load_busy_o),
    .load_done_o     (load_done_o),
    .load_data_o     (load_data_o),
    .probe_addr_o    (probe_addr),
    .probe_size_o    (probe_size),
    .ld_req_valid_o  (ld_req_valid),
    .ld_req_o        (ld_req)
  );

  // load unit times the read return by its own state, flag has no user here
  dcache_arbiter arb_i (
    .clock          (clock),
    .reset          (reset),
    .ld_req_valid_i (ld_req_valid),
    .ld_req_i       (ld_req),
    .st_req_valid_i (st_req_valid),
    .st_req_i       (st_req),
    .ld_accept_o    (ld_accept),
    .st_accept_o    (st_accept),
    .mem_valid_o    (mem_valid),
    .mem_req_o      (mem_req),
    .rd_pending_o   ()
  );

  data_mem mem_i (
    .clock       (clock),
    .reset       (reset),
    .mem_valid_i (mem_valid),
    .mem_req_i   (mem_req),
    .rdata_o     (mem_rdata)
  );

endmodule

`default_nettype wire

// File: design/store_queue.sv
`default_nettype none

module store_queue import lsu_pkg::*; (
  input  wire logic       clock,
  input  wire logic       reset,
  // store address, program order
  input  wire logic       enq_valid_i,
  input  wire addr_t      enq_addr_i,
  input  wire mem_size_e  enq_size_i,
  input  wire rob_idx_t   enq_rob_idx_i,
  // store data, matched by rob tag
  input  wire logic       data_valid_i,
  input  wire mem_block_t data_i,
  input  wire rob_idx_t   data_rob_idx_i,
  // commit notice from the rob
  input  wire logic       commit_valid_i,
  input  wire rob_idx_t   commit_rob_idx_i,
  // forwarding probe from the load unit
  input  wire addr_t      load_addr_i,
  input  wire mem_size_e  load_size_i,
  input  wire logic       st_req_accept_i,
  output logic            sq_full_o,
  output logic            sq_empty_o,
  output fwd_resp_t       fwd_o,
  output logic            st_req_valid_o,
  output mem_req_t        st_req_o
);

  sq_entry_t             sq_q [SQ_SIZE];
  logic [SQ_IDX_W-1:0]   head_q;
  logic [SQ_IDX_W-1:0]   tail_q;
  logic [SQ_CNT_W-1:0]   count_q;

  logic                  push;
  logic                  pop;
  logic                  data_found;
  logic [SQ_IDX_W-1:0]   data_idx;
  logic                  commit_found;
  logic [SQ_IDX_W-1:0]   commit_idx;
  logic                  scan_done;
  logic [SQ_IDX_W-1:0]   scan_idx;

  // ========================================
  // pointer and range helpers
  // ========================================

  function automatic logic [SQ_IDX_W-1:0] next_ptr(logic [SQ_IDX_W-1:0] ptr);
    if (ptr == SQ_IDX_W'(SQ_SIZE - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  function automatic logic [SQ_IDX_W-1:0] prev_ptr(logic [SQ_IDX_W-1:0] ptr);
    if (ptr == '0) begin
      return SQ_IDX_W'(SQ_SIZE - 1);
    end
    return ptr - 1'b1;
  endfunction

  // exclusive end address, one bit wider so nothing wraps
  function automatic logic [ADDR_W:0] end_addr(addr_t a, mem_size_e sz);
    return {1'b0, a} + {{(ADDR_W - 3){1'b0}}, size_bytes(sz)};
  endfunction

  function automatic logic overlaps(addr_t st_a, mem_size_e st_sz, addr_t ld_a,
                                    mem_size_e ld_sz);
    return ({1'b0, st_a} < end_addr(ld_a, ld_sz)) && ({1'b0, ld_a} < end_addr(st_a, st_sz));
  endfunction

  function automatic logic covers(addr_t st_a, mem_size_e st_sz, addr_t ld_a,
                                  mem_size_e ld_sz);
    return (st_a <= ld_a) && (end_addr(ld_a, ld_sz) <= end_addr(st_a, st_sz));
  endfunction

  // ========================================
  // occupancy and drain request
  // ========================================

  assign sq_full_o  = (count_q == SQ_CNT_W'(SQ_SIZE));
  assign sq_empty_o = (count_q == '0);

  // head leaves only once committed with its data
  assign st_req_valid_o = sq_q[head_q].valid && sq_q[head_q].committed &&
                          sq_q[head_q].data_valid;
  assign st_req_o.cmd   = mem_store;
  assign st_req_o.addr  = sq_q[head_q].addr;
  assign st_req_o.size  = sq_q[head_q].size;
  assign st_req_o.data  = sq_q[head_q].data;

  assign push = enq_valid_i && !sq_full_o;
  assign pop  = st_req_valid_o && st_req_accept_i;

  // first slot holding the data tag
  always_comb begin
    data_found = 1'b0;
    data_idx   = '0;
    for (int i = 0; i < SQ_SIZE; i++) begin
      if (!data_found && sq_q[i].valid && (sq_q[i].rob_idx == data_rob_idx_i)) begin
        data_found = 1'b1;
        data_idx   = SQ_IDX_W'(i);
      end
    end
  end

  // commit needs the data already present
  always_comb begin
    commit_found = 1'b0;
    commit_idx   = '0;
    for (int i = 0; i < SQ_SIZE; i++) begin
      if (!commit_found && sq_q[i].valid && sq_q[i].data_valid &&
          (sq_q[i].rob_idx == commit_rob_idx_i)) begin
        commit_found = 1'b1;
        commit_idx   = SQ_IDX_W'(i);
      end
    end
  end

  // ========================================
  // queue state
  // ========================================

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      for (int i = 0; i < SQ_SIZE; i++) begin
        sq_q[i].valid      <= 1'b0;
        sq_q[i].data_valid <= 1'b0;
        sq_q[i].committed  <= 1'b0;
      end
    end else begin
      // new store at the tail, data still missing
      if (push) begin
        sq_q[tail_q].valid      <= 1'b1;
        sq_q[tail_q].addr       <= enq_addr_i;
        sq_q[tail_q].size       <= enq_size_i;
        sq_q[tail_q].rob_idx    <= enq_rob_idx_i;
        sq_q[tail_q].data_valid <= 1'b0;
        sq_q[tail_q].committed  <= 1'b0;
        tail_q                  <= next_ptr(tail_q);
      end
      if (data_valid_i && data_found) begin
        sq_q[data_idx].data       <= data_i;
        sq_q[data_idx].data_valid <= 1'b1;
      end
      if (commit_valid_i && commit_found) begin
        sq_q[commit_idx].committed <= 1'b1;
      end
      // head written to memory this edge
      if (pop) begin
        sq_q[head_q].valid      <= 1'b0;
        sq_q[head_q].data_valid <= 1'b0;
        sq_q[head_q].committed  <= 1'b0;
        head_q                  <= next_ptr(head_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ========================================
  // forwarding search
  // ========================================

  // youngest first, stop at the first overlap
  always_comb begin
    fwd_o     = '0;
    scan_done = 1'b0;
    scan_idx  = prev_ptr(tail_q);
    for (int k = 0; k < SQ_SIZE; k++) begin
      if (!scan_done && (SQ_CNT_W'(k) < count_q) && sq_q[scan_idx].valid &&
          overlaps(sq_q[scan_idx].addr, sq_q[scan_idx].size, load_addr_i, load_size_i)) begin
        scan_done = 1'b1;
        if (sq_q[scan_idx].data_valid &&
            covers(sq_q[scan_idx].addr, sq_q[scan_idx].size, load_addr_i, load_size_i)) begin
          fwd_o.hit  = 1'b1;
          fwd_o.data = sq_q[scan_idx].data;
          fwd_o.addr = sq_q[scan_idx].addr;
        end else begin
          // partial overlap or data not there yet
          fwd_o.pending = 1'b1;
        end
      end
      scan_idx = prev_ptr(scan_idx);
    end
  end

endmodule

`default_nettype wire

// File: lsu_top.f
design/lsu_pkg.sv
design/store_queue.sv
design/load_unit.sv
design/dcache_arbiter.sv
design/data_mem.sv
design/lsu_top.sv
testbench/lsu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the lsu testbench with verilator, from the project root
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module lsu_tb -f lsu_top.f -o lsu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/lsu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
  exit 1
fi
exit 0

// File: testbench/lsu_tb.sv
`default_nettype none

module lsu_tb import lsu_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  // ========================================
  // constants and script records
  // ========================================

  localparam int    CLK_PERIOD    = 8;
  localparam int    RESET_CYCLES  = 5;
  // polling limit for one handshake
  localparam int    WAIT_LIMIT    = 100;
  // watchdog budget per script line
  localparam int    CYCLES_PER_OP = 200;
  localparam string SCRIPT_PATH   = "testbench/lsu_testdata.txt";

  // enum names match the script words after the op_ prefix
  typedef enum logic [3:0] {
    op_test, op_enq, op_data, op_commit, op_load, op_issue, op_result,
    op_busy, op_full, op_empty, op_drain, op_bad
  } op_kind_e;

  typedef struct packed {
    op_kind_e    kind;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
  } op_rec_t;

  logic       clock = 1'b0;
  logic       reset;
  logic       enq_valid;
  addr_t      enq_addr;
  mem_size_e  enq_size;
  rob_idx_t   enq_rob_idx;
  logic       data_valid;
  mem_block_t store_data;
  rob_idx_t   data_rob_idx;
  logic       commit_valid;
  rob_idx_t   commit_rob_idx;
  logic       load_req;
  addr_t      load_addr;
  mem_size_e  load_size;
  logic       sq_full;
  logic       sq_empty;
  logic       load_busy;
  logic       load_done;
  mem_block_t load_data;

  op_rec_t    script_q[$];
  logic       script_ready = 1'b0;
  int         error_count  = 0;
  int         check_count  = 0;
  int         test_count   = 0;
  int         test_id      = 0;
  logic       test_open    = 1'b0;
  int         test_checks  = 0;
  int         test_errors  = 0;

  lsu_top dut_i (
    .clock            (clock),
    .reset            (reset),
    .enq_valid_i      (enq_valid),
    .enq_addr_i       (enq_addr),
    .enq_size_i       (enq_size),
    .enq_rob_idx_i    (enq_rob_idx),
    .data_valid_i     (data_valid),
    .data_i           (store_data),
    .data_rob_idx_i   (data_rob_idx),
    .commit_valid_i   (commit_valid),
    .commit_rob_idx_i (commit_rob_idx),
    .load_req_i       (load_req),
    .load_addr_i      (load_addr),
    .load_size_i      (load_size),
    .sq_full_o        (sq_full),
    .sq_empty_o       (sq_empty),
    .load_busy_o      (load_busy),
    .load_done_o      (load_done),
    .load_data_o      (load_data)
  );

  // 8 ns period
  always #(CLK_PERIOD / 2) clock = ~clock;

  // ========================================
  // bookkeeping
  // ========================================

  function automatic op_kind_e decode_op(string name);
    op_kind_e k;
    k = op_test;
    for (int i = 0; i < k.num(); i++) begin
      if (k.name() == {"op_", name}) begin
        return k;
      end
      k = k.next();
    end
    return op_bad;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    check_count++;
    test_checks++;
    if (got !== expected) begin
      error_count++;
      test_errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
    end
  endtask

  task automatic report_failure(input string what);
    error_count++;
    test_errors++;
    $display("failure in test %0d at %0t: %s", test_id, $time, what);
  endtask

  task automatic close_test();
    if (test_open) begin
      test_count++;
      $display("test %0d done: %0d checks, %0d errors", test_id, test_checks, test_errors);
    end
  endtask

  task automatic open_test(input int id);
    close_test();
    test_open   = 1'b1;
    test_id     = id;
    test_checks = 0;
    test_errors = 0;
  endtask

  // one operation per line, three hex columns after the word
  task automatic read_script();
    int          fd;
    int          fields;
    int          line_no;
    string       line;
    string       name;
    logic [63:0] a_f;
    logic [63:0] b_f;
    logic [63:0] c_f;
    op_rec_t     rec;
    fd = $fopen(SCRIPT_PATH, "r");
    if (fd == 0) begin
      report_failure($sformatf("cannot open %s", SCRIPT_PATH));
    end else begin
      line_no = 0;
      while ($fgets(line, fd) != 0) begin
        line_no++;
        // skip comment lines
        if (line.len() > 0 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%s %h %h %h", name, a_f, b_f, c_f);
          if (fields == 4) begin
            rec.kind = decode_op(name);
            rec.a    = a_f;
            rec.b    = b_f;
            rec.c    = c_f;
            if (rec.kind == op_bad) begin
              report_failure($sformatf("unknown operation on script line %0d", line_no));
            end else begin
              script_q.push_back(rec);
            end
          end else if (fields > 0) begin
            report_failure($sformatf("script line %0d has too few columns", line_no));
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ========================================
  // drivers, all start and end on a falling edge
  // ========================================

  task automatic drive_enqueue(input op_rec_t rec);
    // no enqueue against a full queue
    if (sq_full) begin
      report_failure("enqueue attempted while the store queue was full");
    end else begin
      enq_valid   = 1'b1;
      enq_addr    = rec.a[ADDR_W-1:0];
      enq_size    = mem_size_e'(rec.b[1:0]);
      enq_rob_idx = rec.c[ROB_IDX_W-1:0];
      @(negedge clock);
      enq_valid   = 1'b0;
    end
  endtask

  task automatic drive_data(input op_rec_t rec);
    data_valid   = 1'b1;
    data_rob_idx = rec.a[ROB_IDX_W-1:0];
    store_data   = rec.b;
    @(negedge clock);
    data_valid   = 1'b0;
  endtask

  task automatic drive_commit(input op_rec_t rec);
    commit_valid   = 1'b1;
    commit_rob_idx = rec.a[ROB_IDX_W-1:0];
    @(negedge clock);
    commit_valid   = 1'b0;
  endtask

  task automatic issue_load(input addr_t addr, input mem_size_e size);
    if (load_busy) begin
      report_failure("load issued while the load unit was still busy");
    end else begin
      load_req  = 1'b1;
      load_addr = addr;
      load_size = size;
      @(negedge clock);
      load_req  = 1'b0;
    end
  endtask

  // forwarded, memory or stalled loads all end in one done pulse
  task automatic wait_load_result(input logic [63:0] expected);
    int cycles;
    cycles = 0;
    while (!load_done && cycles < WAIT_LIMIT) begin
      @(negedge clock);
      cycles++;
    end
    if (load_done) begin
      check_value("load_data_o", load_data, expected);
      // done lasts a single cycle
      @(negedge clock);
      check_value("load_done_o", 64'(load_done), 64'h0);
    end else begin
      report_failure("load_done_o never pulsed after the load was issued");
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (!sq_empty && cycles < WAIT_LIMIT) begin
      @(negedge clock);
      cycles++;
    end
    if (!sq_empty) begin
      report_failure("store queue did not drain to empty");
    end
  endtask

  task automatic run_op(input op_rec_t rec);
    case (rec.kind)
      op_test:   open_test(int'(rec.a));
      op_enq:    drive_enqueue(rec);
      op_data:   drive_data(rec);
      op_commit: drive_commit(rec);
      op_load: begin
        issue_load(rec.a[ADDR_W-1:0], mem_size_e'(rec.b[1:0]));
        wait_load_result(rec.c);
      end
      op_issue:  issue_load(rec.a[ADDR_W-1:0], mem_size_e'(rec.b[1:0]));
      op_result: wait_load_result(rec.a);
      op_busy:   check_value("load_busy_o", 64'(load_busy), rec.a);
      op_full:   check_value("sq_full_o", 64'(sq_full), rec.a);
      op_empty:  check_value("sq_empty_o", 64'(sq_empty), rec.a);
      op_drain:  wait_drain();
      default:   report_failure("operation could not be decoded");
    endcase
  endtask

  // ========================================
  // main sequence and watchdog
  // ========================================

  initial begin
    reset          = 1'b1;
    enq_valid      = 1'b0;
    enq_addr       = '0;
    enq_size       = size_byte;
    enq_rob_idx    = '0;
    data_valid     = 1'b0;
    store_data     = '0;
    data_rob_idx   = '0;
    commit_valid   = 1'b0;
    commit_rob_idx = '0;
    load_req       = 1'b0;
    load_addr      = '0;
    load_size      = size_byte;
    read_script();
    script_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    foreach (script_q[i]) begin
      run_op(script_q[i]);
    end
    close_test();
    if (check_count == 0) begin
      report_failure("no checks were run");
    end
    $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // budget scales with the script length
  initial begin
    wait (script_ready);
    repeat (RESET_CYCLES + (script_q.size() + 1) * CYCLES_PER_OP) @(posedge clock);
    $display("watchdog expired before the script completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/lsu_testdata.txt
# columns: op a b c, numbers in hex; size 0 byte, 1 half, 2 word, 3 double
# enq addr size rob / data rob value / commit rob / load addr size expect / issue addr size
# result expect / busy, full, empty level / drain / test id
test 1 0 0
full 0 0 0
empty 1 0 0
busy 0 0 0
load 100 3 0
load 7f0 2 0
test 2 0 0
enq 200 3 1
data 1 1122334455667788 0
enq 204 2 2
data 2 aabbccdd 0
load 204 1 ccdd
load 206 0 bb
load 200 2 55667788
load 202 1 5566
commit 1 0 0
commit 2 0 0
drain 0 0 0
test 3 0 0
enq 304 2 3
issue 300 3 0
busy 1 0 0
data 3 deadbeef 0
busy 1 0 0
commit 3 0 0
result deadbeef00000000 0 0
drain 0 0 0
test 4 0 0
enq 400 3 4
data 4 0123456789abcdef 0
enq 402 1 5
data 5 beef 0
enq 407 0 6
data 6 5a 0
enq 404 0 7
data 7 c3 0
commit 4 0 0
commit 5 0 0
commit 6 0 0
commit 7 0 0
drain 0 0 0
load 400 3 5a2345c3beefcdef
load 404 2 5a2345c3
load 402 1 beef
load 407 0 5a
load 406 1 5a23
load 400 2 beefcdef
load 200 3 aabbccdd55667788
load 304 2 deadbeef
test 5 0 0
enq 500 3 8
enq 508 3 9
enq 510 3 a
enq 518 3 b
enq 520 3 c
enq 528 3 d
enq 530 3 e
full 0 0 0
enq 538 3 f
full 1 0 0
empty 0 0 0
data 8 f0 0
data 9 f1 0
data a f2 0
data b f3 0
data c f4 0
data d f5 0
data e f6 0
data f f7 0
commit 8 0 0
commit 9 0 0
commit a 0 0
commit b 0 0
commit c 0 0
commit d 0 0
commit e 0 0
commit f 0 0
drain 0 0 0
full 0 0 0
empty 1 0 0
load 538 3 f7
load 500 0 f0
